// File: src/video_pkg.sv
package video_pkg;

    // ------------------------------------------------------------------------
    //  pixel formats
    // ------------------------------------------------------------------------

    // raw sensor sample and converted output sample
    localparam int raw_bits  = 10;
    localparam int gray_bits = 8;

    // defaults for the top level, two pixels per beat
    localparam int default_lanes     = 2;
    localparam int default_size_bits = 15;

    // ------------------------------------------------------------------------
    //  register map
    // ------------------------------------------------------------------------

    localparam int reg_addr_bits = 2;
    localparam int reg_data_bits = 16;

    // black level, read/write
    localparam logic [reg_addr_bits-1:0] reg_addr_black  = 2'd0;
    // measured geometry, read only
    localparam logic [reg_addr_bits-1:0] reg_addr_width  = 2'd1;
    localparam logic [reg_addr_bits-1:0] reg_addr_height = 2'd2;
    // sticky error in the top bit, frame count below it
    localparam logic [reg_addr_bits-1:0] reg_addr_status = 2'd3;

    localparam int status_error_bit = reg_data_bits - 1;

endpackage

// File: src/stream_skid.sv
module stream_skid
    #(
        parameter type payload_t = logic
    )
    (
        input  logic     aclk,
        input  logic     reset,

        input  payload_t in_data,
        input  logic     in_valid,
        output logic     in_ready,

        output payload_t out_data,
        output logic     out_valid,
        input  logic     out_ready
    );

    // main register drives the output, spare catches a beat during a stall
    payload_t main_data;
    payload_t spare_data;
    logic     main_valid;
    logic     spare_valid;

    logic     accept;
    logic     take;
    logic     main_free;

    assign accept    = in_valid && in_ready;
    assign take      = main_valid && out_ready;
    assign main_free = take || !main_valid;

    // ready comes straight from a flop, low only with both entries full
    assign in_ready  = !spare_valid;
    assign out_data  = main_data;
    assign out_valid = main_valid;

    // ------------------------------------------------------------------------
    //  control
    // ------------------------------------------------------------------------

    always_ff @(posedge aclk) begin
        if (reset) begin
            main_valid  <= 1'b0;
            spare_valid <= 1'b0;
        end else if (main_free) begin
            // spare has priority, it is older than any new beat
            main_valid  <= spare_valid || accept;
            spare_valid <= 1'b0;
        end else if (accept) begin
            spare_valid <= 1'b1;
        end
    end

    // ------------------------------------------------------------------------
    //  payload
    // ------------------------------------------------------------------------

    always_ff @(posedge aclk) begin
        if (main_free) begin
            main_data <= spare_valid ? spare_data : in_data;
        end
        if (!main_free && accept) begin
            spare_data <= in_data;
        end
    end

endmodule

// File: src/frame_monitor.sv
module frame_monitor
    import video_pkg::*;
    #(
        parameter int lanes     = 2,
        parameter int size_bits = 15
    )
    (
        input  logic                      aclk,
        input  logic                      reset,

        input  logic [lanes*raw_bits-1:0] s_tdata,
        input  logic                      s_tuser,
        input  logic                      s_tlast,
        input  logic                      s_tvalid,
        output logic                      s_tready,

        output logic [lanes*raw_bits-1:0] mid_tdata,
        output logic                      mid_tuser,
        output logic                      mid_tlast,
        output logic                      mid_valid,
        input  logic                      mid_ready,

        output logic [size_bits-1:0]      img_width,
        output logic [size_bits-1:0]      img_height,
        output logic                      geom_error
    );

    typedef struct packed {
        logic                      tuser;
        logic                      tlast;
        logic [lanes*raw_bits-1:0] tdata;
    } in_payload_t;

    in_payload_t          skid_in;
    in_payload_t          skid_out;

    logic                 s_beat;
    logic [size_bits-1:0] beat_cnt;
    logic [size_bits-1:0] line_cnt;
    logic                 width_known;

    logic [size_bits-1:0] beat_base;
    logic [size_bits-1:0] line_base;
    logic [size_bits-1:0] line_beats;
    logic [size_bits-1:0] line_width;
    logic                 known_base;

    // ------------------------------------------------------------------------
    //  geometry measurement on the input side
    // ------------------------------------------------------------------------

    assign s_beat = s_tvalid && s_tready;

    // tuser restarts the frame, even in the middle of a line
    always_comb begin
        beat_base  = s_tuser ? '0 : beat_cnt;
        line_base  = s_tuser ? '0 : line_cnt;
        known_base = s_tuser ? 1'b0 : width_known;
        line_beats = beat_base + 1'b1;
        line_width = size_bits'(line_beats * lanes);
    end

    always_ff @(posedge aclk) begin
        if (reset) begin
            beat_cnt    <= '0;
            line_cnt    <= '0;
            width_known <= 1'b0;
            img_width   <= '0;
            img_height  <= '0;
            geom_error  <= 1'b0;
        end else if (s_beat) begin
            // height of the previous frame, only once a line was seen
            if (s_tuser && line_cnt != '0) begin
                img_height <= line_cnt;
            end
            if (s_tlast) begin
                beat_cnt    <= '0;
                line_cnt    <= line_base + 1'b1;
                img_width   <= line_width;
                width_known <= 1'b1;
                if (known_base && line_width != img_width) begin
                    geom_error <= 1'b1;
                end
            end else begin
                beat_cnt    <= line_beats;
                line_cnt    <= line_base;
                width_known <= known_base;
            end
        end
    end

    // ------------------------------------------------------------------------
    //  input buffer
    // ------------------------------------------------------------------------

    assign skid_in = '{tuser: s_tuser, tlast: s_tlast, tdata: s_tdata};

    stream_skid #(.payload_t(in_payload_t)) u_in_skid (
        .aclk      (aclk),
        .reset     (reset),
        .in_data   (skid_in),
        .in_valid  (s_tvalid),
        .in_ready  (s_tready),
        .out_data  (skid_out),
        .out_valid (mid_valid),
        .out_ready (mid_ready)
    );

    assign mid_tdata = skid_out.tdata;
    assign mid_tuser = skid_out.tuser;
    assign mid_tlast = skid_out.tlast;

endmodule

// File: src/pixel_lane.sv
module pixel_lane
    import video_pkg::*;
    (
        input  logic [raw_bits-1:0]  raw_pixel,
        input  logic [raw_bits-1:0]  black_level,
        output logic [gray_bits-1:0] gray_pixel
    );

    // low bits dropped in the conversion
    localparam int drop_bits = raw_bits - gray_bits;

    logic [raw_bits-1:0]  level;
    logic [raw_bits:0]    rounded;
    logic [gray_bits:0]   scaled;

    always_comb begin
        // clamp at zero below the black level
        level = (raw_pixel > black_level) ? raw_pixel - black_level : '0;

        // round half up, one extra bit for the carry
        rounded = {1'b0, level} + (raw_bits + 1)'(1 << (drop_bits - 1));
        scaled  = rounded[raw_bits:drop_bits];

        // top bit set means the rounding went past full scale
        gray_pixel = scaled[gray_bits] ? '1 : scaled[gray_bits-1:0];
    end

endmodule

// File: src/video_output_stage.sv
module video_output_stage
    import video_pkg::*;
    #(
        parameter int lanes = 2
    )
    (
        input  logic                       aclk,
        input  logic                       reset,

        input  logic [lanes*gray_bits-1:0] lane_pixels,
        input  logic                       mid_tuser,
        input  logic                       mid_tlast,
        input  logic                       mid_valid,
        output logic                       mid_ready,

        output logic [lanes*gray_bits-1:0] m_tdata,
        output logic                       m_tuser,
        output logic                       m_tlast,
        output logic                       m_tvalid,
        input  logic                       m_tready,

        output logic [reg_data_bits-2:0]   frame_count
    );

    typedef struct packed {
        logic                       tuser;
        logic                       tlast;
        logic [lanes*gray_bits-1:0] tdata;
    } out_payload_t;

    out_payload_t skid_in;
    out_payload_t skid_out;

    // ------------------------------------------------------------------------
    //  output buffer
    // ------------------------------------------------------------------------

    assign skid_in = '{tuser: mid_tuser, tlast: mid_tlast, tdata: lane_pixels};

    stream_skid #(.payload_t(out_payload_t)) u_out_skid (
        .aclk      (aclk),
        .reset     (reset),
        .in_data   (skid_in),
        .in_valid  (mid_valid),
        .in_ready  (mid_ready),
        .out_data  (skid_out),
        .out_valid (m_tvalid),
        .out_ready (m_tready)
    );

    assign m_tdata = skid_out.tdata;
    assign m_tuser = skid_out.tuser;
    assign m_tlast = skid_out.tlast;

    // frames started at the output, wraps silently
    always_ff @(posedge aclk) begin
        if (reset) begin
            frame_count <= '0;
        end else if (m_tvalid && m_tready && m_tuser) begin
            frame_count <= frame_count + 1'b1;
        end
    end

endmodule

// File: src/video_regs.sv
module video_regs
    import video_pkg::*;
    #(
        parameter int size_bits = 15
    )
    (
        input  logic                     aclk,
        input  logic                     reset,

        input  logic                     reg_we,
        input  logic [reg_addr_bits-1:0] reg_addr,
        input  logic [reg_data_bits-1:0] reg_wdata,
        output logic [reg_data_bits-1:0] reg_rdata,

        input  logic [size_bits-1:0]     img_width,
        input  logic [size_bits-1:0]     img_height,
        input  logic                     geom_error,
        input  logic [reg_data_bits-2:0] frame_count,

        output logic [raw_bits-1:0]      black_level
    );

    // only the black level is writable
    always_ff @(posedge aclk) begin
        if (reset) begin
            black_level <= '0;
        end else if (reg_we && reg_addr == reg_addr_black) begin
            black_level <= reg_wdata[raw_bits-1:0];
        end
    end

    // read mux, unused bits zero
    always_comb begin
        reg_rdata = '0;
        case (reg_addr)
            reg_addr_black:  reg_rdata = reg_data_bits'(black_level);
            reg_addr_width:  reg_rdata = reg_data_bits'(img_width);
            reg_addr_height: reg_rdata = reg_data_bits'(img_height);
            reg_addr_status: begin
                reg_rdata[status_error_bit]   = geom_error;
                reg_rdata[reg_data_bits-2:0]  = frame_count;
            end
            default:         reg_rdata = '0;
        endcase
    end

endmodule

// File: src/raw_to_gray_top.sv
module raw_to_gray_top
    import video_pkg::*;
    #(
        parameter int lanes     = default_lanes,
        parameter int size_bits = default_size_bits
    )
    (
        input  logic                       aclk,
        input  logic                       reset,

        input  logic [lanes*raw_bits-1:0]  s_tdata,
        input  logic                       s_tuser,
        input  logic                       s_tlast,
        input  logic                       s_tvalid,
        output logic                       s_tready,

        output logic [lanes*gray_bits-1:0] m_tdata,
        output logic                       m_tuser,
        output logic                       m_tlast,
        output logic                       m_tvalid,
        input  logic                       m_tready,

        input  logic                       reg_we,
        input  logic [reg_addr_bits-1:0]   reg_addr,
        input  logic [reg_data_bits-1:0]   reg_wdata,
        output logic [reg_data_bits-1:0]   reg_rdata
    );

    logic [lanes*raw_bits-1:0]  mid_tdata;
    logic                       mid_tuser;
    logic                       mid_tlast;
    logic                       mid_valid;
    logic                       mid_ready;
    logic [lanes*gray_bits-1:0] lane_pixels;

    logic [size_bits-1:0]       img_width;
    logic [size_bits-1:0]       img_height;
    logic                       geom_error;
    logic [reg_data_bits-2:0]   frame_count;
    logic [raw_bits-1:0]        black_level;

    // ------------------------------------------------------------------------
    //  input side, measurement and buffer
    // ------------------------------------------------------------------------

    frame_monitor #(.lanes(lanes), .size_bits(size_bits)) u_frame_monitor (
        .aclk       (aclk),
        .reset      (reset),
        .s_tdata    (s_tdata),
        .s_tuser    (s_tuser),
        .s_tlast    (s_tlast),
        .s_tvalid   (s_tvalid),
        .s_tready   (s_tready),
        .mid_tdata  (mid_tdata),
        .mid_tuser  (mid_tuser),
        .mid_tlast  (mid_tlast),
        .mid_valid  (mid_valid),
        .mid_ready  (mid_ready),
        .img_width  (img_width),
        .img_height (img_height),
        .geom_error (geom_error)
    );

    // one converter per pixel of the beat
    for (genvar i = 0; i < lanes; i++) begin : g_lane
        pixel_lane u_pixel_lane (
            .raw_pixel   (mid_tdata[i*raw_bits +: raw_bits]),
            .black_level (black_level),
            .gray_pixel  (lane_pixels[i*gray_bits +: gray_bits])
        );
    end

    // ------------------------------------------------------------------------
    //  output side and registers
    // ------------------------------------------------------------------------

    video_output_stage #(.lanes(lanes)) u_output_stage (
        .aclk        (aclk),
        .reset       (reset),
        .lane_pixels (lane_pixels),
        .mid_tuser   (mid_tuser),
        .mid_tlast   (mid_tlast),
        .mid_valid   (mid_valid),
        .mid_ready   (mid_ready),
        .m_tdata     (m_tdata),
        .m_tuser     (m_tuser),
        .m_tlast     (m_tlast),
        .m_tvalid    (m_tvalid),
        .m_tready    (m_tready),
        .frame_count (frame_count)
    );

    video_regs #(.size_bits(size_bits)) u_regs (
        .aclk        (aclk),
        .reset       (reset),
        .reg_we      (reg_we),
        .reg_addr    (reg_addr),
        .reg_wdata   (reg_wdata),
        .reg_rdata   (reg_rdata),
        .img_width   (img_width),
        .img_height  (img_height),
        .geom_error  (geom_error),
        .frame_count (frame_count),
        .black_level (black_level)
    );

endmodule

// File: verif/raw_to_gray_chk.sv
module raw_to_gray_chk
    import video_pkg::*;
    #(
        parameter int lanes = 2
    )
    (
        input logic                       aclk,
        input logic                       reset,
        input logic [lanes*raw_bits-1:0]  s_tdata,
        input logic                       s_tuser,
        input logic                       s_tlast,
        input logic                       s_tvalid,
        input logic                       s_tready,
        input logic [lanes*gray_bits-1:0] m_tdata,
        input logic                       m_tuser,
        input logic                       m_tlast,
        input logic                       m_tvalid,
        input logic                       m_tready
    );
    timeunit 1ns;
    timeprecision 100ps;

    // a stalled input beat holds until it transfers
    a_in_hold: assert property (@(posedge aclk) disable iff (reset)
        s_tvalid && !s_tready |=> s_tvalid && $stable(s_tdata)
            && $stable(s_tuser) && $stable(s_tlast))
        else $error("input beat changed while stalled");

    a_out_hold: assert property (@(posedge aclk) disable iff (reset)
        m_tvalid && !m_tready |=> m_tvalid && $stable(m_tdata)
            && $stable(m_tuser) && $stable(m_tlast))
        else $error("output beat changed while stalled");

    a_reset_idle: assert property (@(posedge aclk) reset |=> !m_tvalid)
        else $error("m_tvalid high during reset");

    // lines are wider than one beat, so a frame start never ends a line
    a_user_last: assert property (@(posedge aclk) disable iff (reset)
        m_tvalid && m_tuser |-> !m_tlast)
        else $error("m_tuser and m_tlast high on the same beat");

endmodule

bind raw_to_gray_top raw_to_gray_chk #(.lanes(lanes)) i_chk (
    .aclk     (aclk),
    .reset    (reset),
    .s_tdata  (s_tdata),
    .s_tuser  (s_tuser),
    .s_tlast  (s_tlast),
    .s_tvalid (s_tvalid),
    .s_tready (s_tready),
    .m_tdata  (m_tdata),
    .m_tuser  (m_tuser),
    .m_tlast  (m_tlast),
    .m_tvalid (m_tvalid),
    .m_tready (m_tready)
);

// File: verif/tb_raw_to_gray.sv
module tb_raw_to_gray
    import video_pkg::*;
    ();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int lanes          = 2;
    localparam int frame_width    = 16;
    localparam int frame_height   = 4;
    localparam int frames_sent    = 9;
    localparam int total_beats    = frames_sent * frame_height * frame_width / lanes;
    localparam int timeout_cycles = 4 * total_beats + 2000;

    logic                       aclk;
    logic                       reset;
    logic [lanes*raw_bits-1:0]  s_tdata;
    logic                       s_tuser;
    logic                       s_tlast;
    logic                       s_tvalid;
    logic                       s_tready;
    logic [lanes*gray_bits-1:0] m_tdata;
    logic                       m_tuser;
    logic                       m_tlast;
    logic                       m_tvalid;
    logic                       m_tready;
    logic                       reg_we;
    logic [reg_addr_bits-1:0]   reg_addr;
    logic [reg_data_bits-1:0]   reg_wdata;
    logic [reg_data_bits-1:0]   reg_rdata;

    // expected output beats as {tuser, tlast, data}
    logic [lanes*gray_bits+1:0] expected[$];
    int                         black_model;
    bit                         gap_en;
    bit                         stall_en;
    int unsigned                seed_ret;

    raw_to_gray_top #(.lanes(lanes)) i_dut (
        .aclk      (aclk),
        .reset     (reset),
        .s_tdata   (s_tdata),
        .s_tuser   (s_tuser),
        .s_tlast   (s_tlast),
        .s_tvalid  (s_tvalid),
        .s_tready  (s_tready),
        .m_tdata   (m_tdata),
        .m_tuser   (m_tuser),
        .m_tlast   (m_tlast),
        .m_tvalid  (m_tvalid),
        .m_tready  (m_tready),
        .reg_we    (reg_we),
        .reg_addr  (reg_addr),
        .reg_wdata (reg_wdata),
        .reg_rdata (reg_rdata)
    );

    initial begin
        aclk = 1'b0;
        forever #20 aclk = ~aclk;
    end

    // -------------------------------------------------------------------------
    //  checking and reference model
    // -------------------------------------------------------------------------

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("TESTBENCH FAILED");
        $fatal(1, "run aborted");
    endtask

    task automatic check_value(input string name, input logic [31:0] want,
                               input logic [31:0] got);
        if (want !== got) begin
            abort_run($sformatf("FAIL time %0t %s expected %0h actual %0h",
                                $time, name, want, got));
        end
    endtask

    // subtract, clamp at zero, round half up to 8 bits, saturate
    function automatic int gray_of(input int p, input int bl);
        int v;
        v = p - bl;
        if (v < 0) v = 0;
        v = (v + 2) / 4;
        if (v > 255) v = 255;
        return v;
    endfunction

    // bias towards full scale and dark pixels
    function automatic int pick_pixel();
        int unsigned roll;
        roll = $urandom % 8;
        if (roll == 0) return 1023;
        if (roll == 1) return int'($urandom % 64);
        return int'($urandom % 1024);
    endfunction

    task automatic push_expected(input logic [lanes*raw_bits-1:0] data,
                                 input logic user, input logic last);
        logic [lanes*gray_bits-1:0] out;
        for (int i = 0; i < lanes; i++) begin
            out[i*gray_bits +: gray_bits] =
                gray_bits'(gray_of(int'(data[i*raw_bits +: raw_bits]), black_model));
        end
        expected.push_back({user, last, out});
    endtask

    // -------------------------------------------------------------------------
    //  stimulus tasks start and end on a falling edge
    // -------------------------------------------------------------------------

    task automatic send_beat(input logic [lanes*raw_bits-1:0] data,
                             input logic user, input logic last);
        int unsigned gap;
        gap = (gap_en && $urandom % 3 == 0) ? 1 + $urandom % 3 : 0;
        s_tvalid = 1'b0;
        repeat (gap) @(negedge aclk);
        s_tdata  = data;
        s_tuser  = user;
        s_tlast  = last;
        s_tvalid = 1'b1;
        // ready is registered, so its value now decides the next edge
        while (s_tready !== 1'b1) @(negedge aclk);
        push_expected(data, user, last);
        @(negedge aclk);
        s_tvalid = 1'b0;
    endtask

    task automatic send_frame(input int short_line, input int short_width,
                              input bit force_corner);
        int                        w;
        int                        beats;
        logic [lanes*raw_bits-1:0] data;
        for (int line = 0; line < frame_height; line++) begin
            w     = (line == short_line) ? short_width : frame_width;
            beats = w / lanes;
            for (int b = 0; b < beats; b++) begin
                for (int i = 0; i < lanes; i++) begin
                    data[i*raw_bits +: raw_bits] = raw_bits'(pick_pixel());
                end
                if (force_corner && line == 0 && b == 0) begin
                    data[raw_bits-1:0]          = 10'd1023;
                    data[2*raw_bits-1:raw_bits] = 10'd40;
                end
                send_beat(data, line == 0 && b == 0, b == beats - 1);
            end
        end
    endtask

    task automatic write_reg(input logic [reg_addr_bits-1:0] addr, input int value);
        reg_addr  = addr;
        reg_wdata = reg_data_bits'(value);
        reg_we    = 1'b1;
        @(negedge aclk);
        reg_we    = 1'b0;
        if (addr == reg_addr_black) black_model = value;
    endtask

    task automatic expect_reg(input logic [reg_addr_bits-1:0] addr,
                              input logic [31:0] value, input string name);
        logic [reg_data_bits-1:0] rdata;
        reg_addr = addr;
        #10;
        rdata = reg_rdata;
        check_value(name, value, 32'(rdata));
        @(negedge aclk);
    endtask

    task automatic drain();
        while (expected.size() != 0) @(negedge aclk);
        repeat (4) @(negedge aclk);
    endtask

    // -------------------------------------------------------------------------
    //  random back-pressure and compare on the output side
    // -------------------------------------------------------------------------

    initial begin
        int unsigned                roll;
        logic                       ready_now;
        logic [lanes*gray_bits+1:0] want;
        m_tready = 1'b1;
        forever begin
            @(negedge aclk);
            roll      = $urandom % 3;
            ready_now = !stall_en || roll != 0;
            m_tready  = ready_now;
            if (m_tvalid === 1'b1 && ready_now) begin
                if (expected.size() == 0) begin
                    abort_run("an output beat arrived with no expected beat left");
                end else begin
                    want = expected.pop_front();
                    check_value("m_tuser", 32'(want[lanes*gray_bits+1]), 32'(m_tuser));
                    check_value("m_tlast", 32'(want[lanes*gray_bits]), 32'(m_tlast));
                    check_value("m_tdata", 32'(want[lanes*gray_bits-1:0]), 32'(m_tdata));
                end
            end
        end
    end

    initial begin
        repeat (timeout_cycles) @(posedge aclk);
        abort_run("watchdog expired before all frames came out of the DUT");
    end

    initial begin
        seed_ret    = $urandom(32'h1394);
        reset       = 1'b1;
        s_tdata     = '0;
        s_tuser     = 1'b0;
        s_tlast     = 1'b0;
        s_tvalid    = 1'b0;
        reg_we      = 1'b0;
        reg_addr    = '0;
        reg_wdata   = '0;
        black_model = 0;
        gap_en      = 1'b0;
        stall_en    = 1'b0;
        repeat (16) @(negedge aclk);
        reset = 1'b0;
        @(negedge aclk);
        // idle handshake state out of reset
        check_value("s_tready", 32'd1, 32'(s_tready));
        check_value("m_tvalid", 32'd0, 32'(m_tvalid));
        expect_reg(reg_addr_black, 32'd0, "black_level");
        expect_reg(reg_addr_status, 32'd0, "status");

        // plain frames without gaps or stalls
        repeat (3) send_frame(-1, 0, 1'b0);
        drain();
        expect_reg(reg_addr_status, 32'd3, "status");

        write_reg(reg_addr_black, 64);
        expect_reg(reg_addr_black, 32'd64, "black_level");
        send_frame(-1, 0, 1'b1);
        drain();

        gap_en   = 1'b1;
        stall_en = 1'b1;
        repeat (3) send_frame(-1, 0, 1'b0);
        drain();
        expect_reg(reg_addr_width, 32'd16, "img_width");
        expect_reg(reg_addr_height, 32'd4, "img_height");
        expect_reg(reg_addr_status, 32'd7, "status");

        // second line short by two beats
        send_frame(1, 12, 1'b0);
        drain();
        expect_reg(reg_addr_status, 32'h8008, "status");
        send_frame(-1, 0, 1'b0);
        drain();
        expect_reg(reg_addr_status, 32'h8009, "status");
        expect_reg(reg_addr_width, 32'd16, "img_width");
        expect_reg(reg_addr_height, 32'd4, "img_height");

        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

// File: all.f
src/video_pkg.sv
src/stream_skid.sv
src/frame_monitor.sv
src/pixel_lane.sv
src/video_output_stage.sv
src/video_regs.sv
src/raw_to_gray_top.sv
verif/raw_to_gray_chk.sv
verif/tb_raw_to_gray.sv

// File: run.sh
#!/bin/sh
# build and run the raw_to_gray simulation with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --timescale 1ns/100ps \
    --top-module tb_raw_to_gray \
    -f all.f \
    -o sim_raw_to_gray

./obj_dir/sim_raw_to_gray
